// ==== rtl/rx_buf_settings.svh ====
// receive buffer manager constants
// ring and tag sizing, completion TLP codes and the read request size table

`ifndef RX_BUF_SETTINGS_SVH
`define RX_BUF_SETTINGS_SVH

// ring address width in QW units
`define RING_AW 9                // 512 QW ring

// outstanding read requests
`define OSR_W 3                  // 8 tags in flight
`define TAG_BASE 5'b00000        // upper tag bits owned by this block

// completion header fields
`define CPL_FMT_TYPE 7'b1001010  // CplD
`define CPL_SC 3'b000            // successful completion

// max read request size in QW per cfg code
`define MAX_RD_QW_128 9'd16
`define MAX_RD_QW_256 9'd32
`define MAX_RD_QW_512 9'd64
`define MAX_RD_QW_1K 9'd128

`endif

// ==== rtl/tlp_pkg.sv ====
// TLP side types
// completion stream beat, outgoing memory read request, request tag

`include "rx_buf_settings.svh"

package tlp_pkg;

    //////////////////////////////////////////////////////////////////////
    // receive stream

    // one 64-bit beat, first dword of the beat in the upper half
    typedef struct packed {
        logic [63:0] data;
        logic        sof;
        logic        eof;
        logic        valid;     // beat present this cycle
    } stream_beat_t;

    //////////////////////////////////////////////////////////////////////
    // read requests

    typedef struct packed {
        logic [63:0] addr;      // host byte address
        logic [8:0]  qw;        // length in QW
    } rd_req_t;

    // low tag bits handed out by the read engine
    typedef logic [`OSR_W-1:0] os_tag_t;

endpackage

// ==== rtl/ring_pkg.sv ====
// receive ring types
// ring pointer with wrap bit, ring write port, request and completion records

`include "rx_buf_settings.svh"

package ring_pkg;

    // top bit is the wrap bit
    typedef logic [`RING_AW:0] ring_ptr_t;

    // one QW write into the ring memory
    typedef struct packed {
        logic                en;
        logic [`RING_AW-1:0] addr;
        logic [63:0]         data;
    } ring_wr_t;

    // issued request as seen by the writer and the tracker
    typedef struct packed {
        logic [`OSR_W-1:0] tag;
        ring_ptr_t         start;   // first QW in the ring
        logic [9:0]        qw;
    } req_rec_t;

    // one completion fully written
    typedef struct packed {
        logic [`OSR_W-1:0] tag;
        logic [8:0]        qw;      // QW carried by this completion
    } cpl_rec_t;

endpackage

// ==== rtl/read_req_gen.sv ====
// read request generator
// descriptor intake and four-phase descriptor handshake
// splitting into max read request sized pieces
// ring space and outstanding request checks, rd_req handshake

`timescale 1ns/1ns
`include "rx_buf_settings.svh"

module read_req_gen import tlp_pkg::*, ring_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              desc_req,
    input  logic [63:0]       desc_addr,
    input  logic [31:0]       desc_len,
    output logic              desc_ack,
    input  logic [2:0]        cfg_max_rd_req_size,
    output logic              rd_req,
    output rd_req_t           rd_req_info,
    input  logic              rd_ack,
    input  os_tag_t           rd_tag,
    input  ring_ptr_t         committed_cons,
    input  logic [`OSR_W:0]   done_count,
    output req_rec_t          new_req,
    output logic              new_req_valid
);

    localparam int RING_QW = 1 << `RING_AW;

    typedef enum logic [2:0] {S_IDLE, S_CALC, S_ACK, S_DROP, S_DONE} state_t;

    state_t              state;
    logic [63:0]         addr;          // host address of next request
    logic [31:0]         len_qw;
    logic [31:0]         qw_done;
    ring_ptr_t           prod;          // producer including requested space
    logic [`OSR_W:0]     issued;

    logic [8:0]          max_qw;
    logic [31:0]         remain;
    logic [8:0]          req_qw;
    ring_ptr_t           fill;
    logic [`RING_AW+1:0] proj;
    logic [`OSR_W:0]     in_flight;
    logic                space_ok;
    logic                osr_ok;

    always_comb begin
        case (cfg_max_rd_req_size)
            3'd0:    max_qw = `MAX_RD_QW_128;
            3'd1:    max_qw = `MAX_RD_QW_256;
            3'd2:    max_qw = `MAX_RD_QW_512;
            default: max_qw = `MAX_RD_QW_1K;  // larger codes capped at 1K
        endcase
    end

    assign remain    = len_qw - qw_done;
    assign req_qw    = (remain > {23'b0, max_qw}) ? max_qw : remain[8:0];
    assign fill      = prod - committed_cons;
    assign proj      = {1'b0, fill} + {2'b0, req_qw};  // ring use after this request
    assign space_ok  = proj <= (`RING_AW+2)'(RING_QW);
    assign in_flight = issued - done_count;
    assign osr_ok    = !in_flight[`OSR_W];  // below 8 outstanding

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= S_IDLE;
            rd_req        <= 1'b0;
            desc_ack      <= 1'b0;
            new_req_valid <= 1'b0;
            prod          <= '0;
            issued        <= '0;
        end else begin
            new_req_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    addr    <= desc_addr;
                    len_qw  <= desc_len;
                    qw_done <= '0;
                    if (desc_req) state <= S_CALC;
                end
                S_CALC: begin
                    if (remain == '0) begin
                        desc_ack <= 1'b1;   // all requests of descriptor acked
                        state    <= S_DONE;
                    end else if (space_ok && osr_ok) begin
                        rd_req           <= 1'b1;
                        rd_req_info.addr <= addr;
                        rd_req_info.qw   <= req_qw;
                        state            <= S_ACK;
                    end
                end
                S_ACK: begin
                    if (rd_ack) begin
                        rd_req        <= 1'b0;
                        new_req_valid <= 1'b1;
                        new_req.tag   <= rd_tag;
                        new_req.start <= prod;
                        new_req.qw    <= {1'b0, rd_req_info.qw};
                        addr          <= addr + {52'b0, rd_req_info.qw, 3'b000};
                        qw_done       <= qw_done + {23'b0, rd_req_info.qw};
                        prod          <= prod + {1'b0, rd_req_info.qw};
                        issued        <= issued + (`OSR_W+1)'(1);
                        state         <= S_DROP;
                    end
                end
                S_DROP: if (!rd_ack) state <= S_CALC;  // engine closes handshake
                S_DONE: begin
                    if (!desc_req) begin
                        desc_ack <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // request stays up until the engine answers
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        $fell(rd_req) |-> $past(rd_ack))
        else $error("rd_req dropped before rd_ack");

endmodule

// ==== rtl/cpl_writer.sv ====
// completion writer
// header filter on format/type, status and tag base
// per-tag ring write pointers loaded from new requests
// dword pairing across beats and byte swap onto the ring write port

`timescale 1ns/1ns
`include "rx_buf_settings.svh"

module cpl_writer import tlp_pkg::*, ring_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  stream_beat_t cpl_in,
    input  req_rec_t     new_req,
    input  logic         new_req_valid,
    output ring_wr_t     ring_wr,
    output cpl_rec_t     cpl_done,
    output logic         cpl_done_valid
);

    localparam int NTAG = 1 << `OSR_W;
    localparam logic [4:0] TAG_PREFIX = `TAG_BASE;

    typedef enum logic [1:0] {S_HDR0, S_HDR1, S_DATA, S_DROP} state_t;

    state_t              state;
    logic                hdr_ok;        // dw0/dw1 checks passed
    logic [9:0]          len_dw;
    os_tag_t             cur_tag;
    logic [31:0]         held_dw;       // even dword waiting for its partner
    logic [`RING_AW-1:0] wr_addr;
    logic [`RING_AW-1:0] wptr [NTAG];

    os_tag_t             beat_tag;
    logic                tag_ok;
    logic                accept;
    logic [8:0]          len_qw;

    function automatic logic [31:0] bswap(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    // header dword 2 sits in the upper half of beat 1
    assign beat_tag = cpl_in.data[40 +: `OSR_W];
    assign tag_ok   = cpl_in.data[44:40+`OSR_W] == TAG_PREFIX[4:`OSR_W];
    assign accept   = hdr_ok && tag_ok;
    assign len_qw   = len_dw[9:1];

    //////////////////////////////////////////////////////////////////////
    // per-tag write pointers

    always_ff @(posedge clk) begin
        if (new_req_valid) begin
            wptr[new_req.tag] <= new_req.start[`RING_AW-1:0];
        end
        // several completions may answer one request
        if (state == S_HDR1 && cpl_in.valid && accept) begin
            wptr[beat_tag] <= wptr[beat_tag] + len_qw;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // filter and pairing FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= S_HDR0;
            ring_wr.en     <= 1'b0;
            cpl_done_valid <= 1'b0;
        end else begin
            ring_wr.en     <= 1'b0;
            cpl_done_valid <= 1'b0;
            case (state)
                S_HDR0: begin
                    if (cpl_in.valid && cpl_in.sof) begin
                        hdr_ok <= (cpl_in.data[62:56] == `CPL_FMT_TYPE) &&
                                  (cpl_in.data[15:13] == `CPL_SC);
                        len_dw <= cpl_in.data[41:32];
                        state  <= S_HDR1;
                    end
                end
                S_HDR1: begin
                    if (cpl_in.valid) begin
                        cur_tag <= beat_tag;
                        held_dw <= cpl_in.data[31:0];   // data dword 0
                        wr_addr <= wptr[beat_tag];
                        if (accept) state <= S_DATA;
                        else if (cpl_in.eof) state <= S_HDR0;
                        else state <= S_DROP;
                    end
                end
                S_DATA: begin
                    if (cpl_in.valid) begin
                        ring_wr.en   <= 1'b1;
                        ring_wr.addr <= wr_addr;
                        ring_wr.data <= {bswap(cpl_in.data[63:32]), bswap(held_dw)};
                        held_dw      <= cpl_in.data[31:0];  // unused on eof beat
                        wr_addr      <= wr_addr + (`RING_AW)'(1);
                        if (cpl_in.eof) begin
                            cpl_done_valid <= 1'b1;
                            cpl_done.tag   <= cur_tag;
                            cpl_done.qw    <= len_qw;
                            state          <= S_HDR0;
                        end
                    end
                end
                S_DROP: if (cpl_in.valid && cpl_in.eof) state <= S_HDR0;
                default: state <= S_HDR0;
            endcase
        end
    end

    // length from beat 0 pairs up exactly once tag is accepted on beat 1
    a_even_len: assert property (@(posedge clk) disable iff (rst)
        (state == S_HDR1 && cpl_in.valid && accept) |-> !len_dw[0])
        else $error("accepted completion with odd dword count");

endmodule

// ==== rtl/commit_tracker.sv ====
// commit tracker
// per-tag start, expected and received QW counts
// in-order advance of the committed producer pointer

`timescale 1ns/1ns
`include "rx_buf_settings.svh"

module commit_tracker import ring_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  req_rec_t        new_req,
    input  logic            new_req_valid,
    input  cpl_rec_t        cpl_done,
    input  logic            cpl_done_valid,
    output ring_ptr_t       committed_prod,
    output logic [`OSR_W:0] done_count
);

    localparam int NTAG = 1 << `OSR_W;

    ring_ptr_t         start  [NTAG];
    logic [9:0]        exp_qw [NTAG];
    logic [9:0]        rcv_qw [NTAG];
    logic [NTAG-1:0]   act;             // request issued and not yet committed
    logic [`OSR_W-1:0] head;            // oldest outstanding tag
    logic              head_done;

    assign head_done = act[head] && (rcv_qw[head] == exp_qw[head]);

    //////////////////////////////////////////////////////////////////////
    // request table

    always_ff @(posedge clk) begin
        if (cpl_done_valid) begin
            rcv_qw[cpl_done.tag] <= rcv_qw[cpl_done.tag] + {1'b0, cpl_done.qw};
        end
        if (new_req_valid) begin
            start[new_req.tag]  <= new_req.start;
            exp_qw[new_req.tag] <= new_req.qw;
            rcv_qw[new_req.tag] <= '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // in-order commit

    always_ff @(posedge clk) begin
        if (rst) begin
            act            <= '0;
            head           <= '0;
            done_count     <= '0;
            committed_prod <= '0;
        end else begin
            if (head_done) begin
                committed_prod <= start[head] + exp_qw[head];  // end of request
                act[head]      <= 1'b0;
                head           <= head + (`OSR_W)'(1);
                done_count     <= done_count + (`OSR_W+1)'(1);
            end
            if (new_req_valid) act[new_req.tag] <= 1'b1;
        end
    end

    // writer never delivers more than was requested for a tag
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        cpl_done_valid |=> (rcv_qw[$past(cpl_done.tag)] <= exp_qw[$past(cpl_done.tag)]))
        else $error("received QW exceed requested QW");

endmodule

// ==== rtl/rx_buf_mgmt.sv ====
// receive buffer manager top level
// read request generator, completion writer and commit tracker

`timescale 1ns/1ns
`include "rx_buf_settings.svh"

module rx_buf_mgmt import tlp_pkg::*, ring_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    // descriptor handshake
    input  logic         desc_req,
    input  logic [63:0]  desc_addr,
    input  logic [31:0]  desc_len,
    output logic         desc_ack,
    input  logic [2:0]   cfg_max_rd_req_size,
    // read engine
    output logic         rd_req,
    output rd_req_t      rd_req_info,
    input  logic         rd_ack,
    input  os_tag_t      rd_tag,
    // completion stream
    input  stream_beat_t cpl_in,
    // ring
    input  ring_ptr_t    committed_cons,
    output ring_ptr_t    committed_prod,
    output ring_wr_t     ring_wr
);

    req_rec_t        new_req;
    logic            new_req_valid;
    cpl_rec_t        cpl_done;
    logic            cpl_done_valid;
    logic [`OSR_W:0] done_count;    // committed requests

    read_req_gen read_req_gen_i (
        .clk                 (clk),
        .rst                 (rst),
        .desc_req            (desc_req),
        .desc_addr           (desc_addr),
        .desc_len            (desc_len),
        .desc_ack            (desc_ack),
        .cfg_max_rd_req_size (cfg_max_rd_req_size),
        .rd_req              (rd_req),
        .rd_req_info         (rd_req_info),
        .rd_ack              (rd_ack),
        .rd_tag              (rd_tag),
        .committed_cons      (committed_cons),
        .done_count          (done_count),
        .new_req             (new_req),
        .new_req_valid       (new_req_valid)
    );

    cpl_writer cpl_writer_i (
        .clk            (clk),
        .rst            (rst),
        .cpl_in         (cpl_in),
        .new_req        (new_req),
        .new_req_valid  (new_req_valid),
        .ring_wr        (ring_wr),
        .cpl_done       (cpl_done),
        .cpl_done_valid (cpl_done_valid)
    );

    commit_tracker commit_tracker_i (
        .clk            (clk),
        .rst            (rst),
        .new_req        (new_req),
        .new_req_valid  (new_req_valid),
        .cpl_done       (cpl_done),
        .cpl_done_valid (cpl_done_valid),
        .committed_prod (committed_prod),
        .done_count     (done_count)
    );

endmodule

// ==== verif/tb_tasks.svh ====
// testbench tasks for the receive buffer manager
// compare tasks, xorshift, completion builder, serving and wait helpers
// directed tests

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// compare tasks

task automatic compare_ring_wr(input ring_wr_t got, input ring_wr_t exp, input string msg);
    if (got !== exp) begin
        $display("MISMATCH @%0t: %s got %0d/%03h/%016h exp %0d/%03h/%016h", $time, msg,
                 got.en, got.addr, got.data, exp.en, exp.addr, exp.data);
        errors++;
    end
endtask

task automatic compare_rd_req(input rd_req_t got, input rd_req_t exp, input string msg);
    if (got !== exp) begin
        $display("MISMATCH @%0t: %s got %016h/%0d exp %016h/%0d", $time, msg,
                 got.addr, got.qw, exp.addr, exp.qw);
        errors++;
    end
endtask

task automatic compare_ptr(input ring_ptr_t got, input ring_ptr_t exp, input string msg);
    if (got !== exp) begin
        $display("MISMATCH @%0t: %s got %0d exp %0d", $time, msg, got, exp);
        errors++;
    end
endtask

function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// host memory content that depends on every address bit
function automatic logic [31:0] host_dword(input logic [63:0] a);
    return (a[31:0] ^ a[63:32]) * 32'h2545_f491 + 32'h1357;
endfunction

function automatic logic [31:0] swap_bytes(input logic [31:0] d);
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
endfunction

task automatic step(input int n);
    repeat (n) begin
        @(posedge clk);
        #2;
    end
endtask

//////////////////////////////////////////////////////////////////////
// completion builder that checks each ring write one cycle after its beat

task automatic send_cpl(input logic [63:0] addr, input ring_ptr_t start, input int qw,
                        input logic [4:0] tag5, input logic [6:0] fmt,
                        input logic [2:0] status, input bit good);
    int           k;
    int           last;
    logic [31:0]  up;
    logic [31:0]  lo;
    ring_wr_t     exp_wr;
    bit           chk;
    logic [`RING_AW-1:0] ra;
    stream_beat_t b;
    chk  = 1'b0;
    last = qw + 1;
    for (k = 0; k <= last; k++) begin
        if (chk) compare_ring_wr(ring_wr, exp_wr, "ring write");
        chk = 1'b0;
        if (k == 0) begin
            up = {1'b0, fmt, 14'b0, 10'(2 * qw)};
            lo = {16'b0, status, 13'b0};
        end else if (k == 1) begin
            up = {19'b0, tag5, 8'b0};
            lo = host_dword(addr);
        end else begin
            up = host_dword(addr + 64'(4 * (2 * k - 3)));
            lo = (k == last) ? 32'h0 : host_dword(addr + 64'(4 * (2 * k - 2)));
            if (good) begin
                ra = start[`RING_AW-1:0] + (`RING_AW)'(k - 2);
                exp_wr.en   = 1'b1;
                exp_wr.addr = ra;
                exp_wr.data = {swap_bytes(up), swap_bytes(host_dword(addr + 64'(4 * (2 * k - 4))))};
                exp_mem[ra] = exp_wr.data;
                exp_vld[ra] = 1'b1;
                chk = 1'b1;
            end
        end
        b.data  = {up, lo};
        b.sof   = (k == 0);
        b.eof   = (k == last);
        b.valid = 1'b1;
        cpl_in  = b;
        step(1);
    end
    if (chk) compare_ring_wr(ring_wr, exp_wr, "ring write");
    cpl_in = '0;
endtask

// answer part of the request at idx while the rest stays queued
task automatic serve_part(input int idx, input int n);
    pend_t p;
    p = pend_q[idx];
    send_cpl(p.addr, p.start, n, {2'b0, p.tag}, `CPL_FMT_TYPE, `CPL_SC, 1'b1);
    if (n == int'(p.qw)) begin
        pend_q.delete(idx);
    end else begin
        p.addr  = p.addr + 64'(8 * n);
        p.start = p.start + (`RING_AW+1)'(n);
        p.qw    = p.qw - 10'(n);
        pend_q[idx] = p;
    end
endtask

task automatic serve_one(input bit shuffle);
    int idx;
    int n;
    idx = shuffle ? int'(xorshift() % pend_q.size()) : 0;
    n   = int'(pend_q[idx].qw);
    if (shuffle && n >= 2 && xorshift() % 2 == 1) n = n / 2;   // two completions
    serve_part(idx, n);
endtask

task automatic wait_commit();
    int guard;
    guard = 0;
    while (commit_cnt != issue_cnt || committed_prod !== exp_prod) begin
        step(1);
        guard++;
        if (guard > 2000) abort_run("committed_prod never reached the last request end");
    end
endtask

task automatic wait_issued(input int cnt);
    int guard;
    guard = 0;
    while (issue_cnt < cnt) begin
        step(1);
        guard++;
        if (guard > 1000) abort_run("expected read request never appeared");
    end
endtask

task automatic start_desc(input logic [63:0] addr, input int len, input logic [2:0] code);
    cfg_max_rd_req_size = code;
    desc_addr = addr;
    desc_len  = 32'(len);
    desc_req  = 1'b1;
endtask

// serve completions until desc_ack, close the handshake, then drain
task automatic finish_desc(input bit shuffle);
    int guard;
    int idle;
    guard = 0;
    idle  = 0;
    while (!desc_ack) begin
        if (pend_q.size() > 0 && (!shuffle || pend_q.size() >= 3 || idle > 20)) begin
            serve_one(shuffle);
            idle = 0;
        end else begin
            step(1);
            idle++;
        end
        guard++;
        if (guard > 20000) abort_run("desc_ack never rose");
    end
    desc_req = 1'b0;
    guard = 0;
    while (desc_ack) begin
        step(1);
        guard++;
        if (guard > 100) abort_run("desc_ack never fell after desc_req dropped");
    end
    while (pend_q.size() > 0) serve_one(shuffle);
    wait_commit();
endtask

task automatic check_ring();
    ring_wr_t got;
    ring_wr_t exp;
    for (int a = 0; a < (1 << `RING_AW); a++) begin
        if (exp_vld[a]) begin
            got = '{1'b1, a[`RING_AW-1:0], mem[a]};
            exp = '{1'b1, a[`RING_AW-1:0], exp_mem[a]};
            compare_ring_wr(got, exp, "ring contents");
        end
    end
endtask

task automatic apply_reset();
    rst = 1'b1;
    desc_req = 1'b0;
    cpl_in = '0;
    follow_cons = 1'b0;
    step(16);
    pend_q.delete();
    req_log.delete();
    bound_q.delete();
    next_tag = '0;
    exp_prod = '0;
    issue_cnt = 0;
    commit_cnt = 0;
    for (int a = 0; a < (1 << `RING_AW); a++) exp_vld[a] = 1'b0;
    rst = 1'b0;
    step(1);
endtask

task automatic end_test(input string name, input int err0);
    if (errors == err0) begin
        tests_ok++;
        $display("test %s: ok", name);
    end else begin
        tests_bad++;
        $display("test %s: FAILED with %0d errors", name, errors - err0);
    end
endtask

//////////////////////////////////////////////////////////////////////
// directed tests

task automatic idle_after_reset();
    int e0;
    e0 = errors;
    if (rd_req !== 1'b0 || desc_ack !== 1'b0 || ring_wr.en !== 1'b0) begin
        $display("MISMATCH @%0t: handshake or ring write not idle after reset", $time);
        errors++;
    end
    compare_ptr(committed_prod, '0, "committed_prod after reset");
    end_test("reset_state", e0);
endtask

task automatic single_request();
    int e0;
    e0 = errors;
    follow_cons = 1'b1;
    start_desc(64'h0000_0001_0000_1000, 12, 3'd0);
    finish_desc(1'b0);
    if (req_log.size() != 1) begin
        $display("MISMATCH @%0t: expected one read request, saw %0d", $time, req_log.size());
        errors++;
    end else begin
        compare_rd_req(req_log[0], '{64'h0000_0001_0000_1000, 9'd12}, "single request");
    end
    compare_ptr(committed_prod, 10'd12, "committed_prod after single request");
    check_ring();
    end_test("single", e0);
endtask

task automatic split_requests();
    int e0;
    logic [63:0] base;
    e0 = errors;
    base = 64'h0000_0002_0000_0000;
    req_log.delete();
    start_desc(base, 100, 3'd0);
    finish_desc(1'b0);
    if (req_log.size() != 7) begin
        $display("MISMATCH @%0t: size code 0 gave %0d requests", $time, req_log.size());
        errors++;
    end else begin
        for (int i = 0; i < 7; i++) begin
            compare_rd_req(req_log[i], '{base + 64'(128 * i), (i < 6) ? 9'd16 : 9'd4},
                           "split 128B");
        end
    end
    req_log.delete();
    start_desc(base, 100, 3'd2);
    finish_desc(1'b0);
    if (req_log.size() != 2) begin
        $display("MISMATCH @%0t: size code 2 gave %0d requests", $time, req_log.size());
        errors++;
    end else begin
        compare_rd_req(req_log[0], '{base, 9'd64}, "split 512B first");
        compare_rd_req(req_log[1], '{base + 64'd512, 9'd36}, "split 512B last");
    end
    end_test("split", e0);
endtask

task automatic shuffled_completions();
    int e0;
    e0 = errors;
    start_desc(64'h0000_0003_0040_0000, 200, 3'd1);
    finish_desc(1'b1);
    start_desc(64'h0000_0003_8000_0100, 90, 3'd0);
    finish_desc(1'b1);
    check_ring();
    end_test("shuffled", e0);
endtask

task automatic filtered_completions();
    int    e0;
    int    w0;
    pend_t p;
    e0 = errors;
    // request kept open so a wrongly accepted completion would finish it
    start_desc(64'h0000_0004_0000_0800, 8, 3'd0);
    wait_issued(issue_cnt + 1);
    p  = pend_q[0];
    w0 = wr_count;
    send_cpl(p.addr, p.start, int'(p.qw), {2'b00, p.tag}, 7'b0001010, `CPL_SC,
             1'b0);  // Cpl without data
    send_cpl(p.addr, p.start, int'(p.qw), {2'b00, p.tag}, `CPL_FMT_TYPE, 3'b001, 1'b0);
    send_cpl(p.addr, p.start, int'(p.qw), {2'b01, p.tag}, `CPL_FMT_TYPE, `CPL_SC, 1'b0);
    step(10);
    if (wr_count != w0) begin
        $display("ERROR @%0t: filtered completion wrote the ring", $time);
        errors++;
    end
    compare_ptr(committed_prod, p.start, "committed_prod after filtered completions");
    finish_desc(1'b0);
    end_test("filter", e0);
endtask

task automatic flow_control();
    int e0;
    int base;
    e0 = errors;
    // ring space with the consumer parked at zero
    start_desc(64'h0000_0005_0000_0000, 640, 3'd3);
    wait_issued(4);
    step(60);
    if (issue_cnt != 4) begin
        $display("ERROR @%0t: request issued with a full ring", $time);
        errors++;
    end
    while (pend_q.size() > 0) serve_one(1'b0);
    wait_commit();
    step(40);
    if (issue_cnt != 4) begin
        $display("ERROR @%0t: request issued before the consumer moved", $time);
        errors++;
    end
    follow_cons = 1'b1;
    finish_desc(1'b0);
    // outstanding limit with completions withheld
    base = issue_cnt;
    start_desc(64'h0000_0006_0000_0000, 144, 3'd0);
    wait_issued(base + 8);
    step(60);
    if (issue_cnt != base + 8) begin
        $display("ERROR @%0t: ninth request issued while eight outstanding", $time);
        errors++;
    end
    serve_one(1'b0);
    finish_desc(1'b0);
    check_ring();
    end_test("flow", e0);
endtask

`endif

// ==== verif/tb_rx_buf_mgmt.sv ====
// testbench top for the receive buffer manager
// clock, reset, DUT, read engine model, ring memory model, commit monitor
// and the directed test sequence

`timescale 1ns/1ns
`include "rx_buf_settings.svh"

module tb_rx_buf_mgmt import tlp_pkg::*, ring_pkg::*; ();

    typedef struct packed {
        logic [63:0] addr;      // host address of first QW still owed
        logic [9:0]  qw;
        os_tag_t     tag;
        ring_ptr_t   start;     // ring position of that QW
    } pend_t;

    logic         clk = 1'b0;
    logic         rst = 1'b1;
    logic         desc_req = 1'b0;
    logic [63:0]  desc_addr = '0;
    logic [31:0]  desc_len = '0;
    logic         desc_ack;
    logic [2:0]   cfg_max_rd_req_size = '0;
    logic         rd_req;
    rd_req_t      rd_req_info;
    logic         rd_ack = 1'b0;
    os_tag_t      rd_tag = '0;
    stream_beat_t cpl_in = '0;
    ring_ptr_t    committed_cons = '0;
    ring_ptr_t    committed_prod;
    ring_wr_t     ring_wr;

    // model state
    pend_t        pend_q[$];
    rd_req_t      req_log[$];
    ring_ptr_t    bound_q[$];       // expected committed_prod values
    os_tag_t      next_tag = '0;
    ring_ptr_t    exp_prod = '0;
    ring_ptr_t    last_prod = '0;
    ring_ptr_t    fill_now;
    int           issue_cnt = 0;
    int           commit_cnt = 0;
    int           wr_count = 0;
    bit           follow_cons = 1'b0;
    logic [63:0]  mem [1 << `RING_AW];
    logic [63:0]  exp_mem [1 << `RING_AW];
    bit           exp_vld [1 << `RING_AW];
    logic [31:0]  rng_state = 32'd17;
    int           errors = 0;
    int           tests_ok = 0;
    int           tests_bad = 0;

    rx_buf_mgmt rx_buf_mgmt_i (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("ERROR @%0t: %s", $time, why);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    initial begin
        #5ms;
        abort_run("simulation ran past its time limit");
    end

    //////////////////////////////////////////////////////////////////////
    // four-phase read engine model with sequential tags

    always @(posedge clk) begin
        #2;
        if (rst) begin
            rd_ack = 1'b0;
        end else if (rd_req && !rd_ack) begin
            fill_now = exp_prod - committed_cons;
            if (int'(fill_now) + int'(rd_req_info.qw) > (1 << `RING_AW)) begin
                $display("ERROR @%0t: request issued beyond ring space", $time);
                errors++;
            end
            if (issue_cnt - commit_cnt >= (1 << `OSR_W)) begin
                $display("ERROR @%0t: request issued past outstanding limit", $time);
                errors++;
            end
            rd_ack = 1'b1;
            rd_tag = next_tag;
            pend_q.push_back('{rd_req_info.addr, {1'b0, rd_req_info.qw}, next_tag, exp_prod});
            req_log.push_back(rd_req_info);
            exp_prod = exp_prod + rd_req_info.qw;
            bound_q.push_back(exp_prod);
            next_tag++;
            issue_cnt++;
        end else if (!rd_req && rd_ack) begin
            rd_ack = 1'b0;
        end
    end

    // ring memory model and commit monitor
    always @(posedge clk) begin
        #1;
        if (ring_wr.en) begin
            mem[ring_wr.addr] = ring_wr.data;
            wr_count++;
        end
        if (rst) begin
            last_prod = '0;
        end else if (committed_prod != last_prod) begin
            if (bound_q.size() == 0) begin
                $display("ERROR @%0t: committed_prod moved with no request finished", $time);
                errors++;
            end else begin
                compare_ptr(committed_prod, bound_q.pop_front(), "commit boundary");
            end
            commit_cnt++;
            last_prod = committed_prod;
        end
    end

    always @(posedge clk) begin
        #2;
        committed_cons = follow_cons ? committed_prod : '0;  // consumer keeps up
    end

    `include "tb_tasks.svh"

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        apply_reset();
        idle_after_reset();
        single_request();
        split_requests();
        shuffled_completions();
        filtered_completions();
        apply_reset();
        flow_control();
        $display("tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== rx_buf_mgmt.f ====
+incdir+rtl
+incdir+verif
rtl/tlp_pkg.sv
rtl/ring_pkg.sv
rtl/read_req_gen.sv
rtl/cpl_writer.sv
rtl/commit_tracker.sv
rtl/rx_buf_mgmt.sv
verif/tb_rx_buf_mgmt.sv

// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_rx_buf_mgmt
FLIST = rx_buf_mgmt.f

SRCS  = $(wildcard rtl/*.sv rtl/*.svh verif/*.sv verif/*.svh)
BIN   = obj_dir/V$(TOP)
LOG   = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
